// ==== design/imuldiv_pkg.sv ====
//--------------------------------------------------------------------------
// shared widths, function codes, FSM states and result word of the
// iterative multiply/divide unit; imported by the RTL and the testbench
//--------------------------------------------------------------------------

package imuldiv_pkg;

  // operand width, fixed by the message format
  localparam int data_width = 32;

  // iteration counter, sized to count the operand bits
  localparam int cntr_width = $clog2(data_width);

  // counter load value, last iteration index
  localparam logic [cntr_width-1:0] iter_count_max = cntr_width'(data_width - 1);

  //------------------------------------------------------------------------
  // function codes
  //------------------------------------------------------------------------

  // fn_div and fn_divu differ only in the signed flag given to the divider
  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_div  = 2'd1,
    fn_divu = 2'd2
  } muldiv_fn_t;

  // idle/calc/done sequencing, shared by the divider and multiplier FSMs
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } div_state_t;

  //------------------------------------------------------------------------
  // result word
  //------------------------------------------------------------------------

  // remainder in the upper half, quotient in the lower half
  typedef struct packed {
    logic [data_width-1:0] remainder;
    logic [data_width-1:0] quotient;
  } div_result_t;

  // one 64-bit word read as a full product or as a division result
  typedef union packed {
    logic [2*data_width-1:0] product;
    div_result_t             divres;
  } muldiv_result_u;

endpackage

// ==== design/int_div_ctrl.sv ====
//--------------------------------------------------------------------------
// divider control FSM; runs the 32 shift-subtract iterations and the
// val/rdy handshake, driving the enables and selects of the datapath
//--------------------------------------------------------------------------

module int_div_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  imuldiv_pkg::muldiv_fn_t divreq_fn,
  input  logic                   divreq_val,
  output logic                   divreq_rdy,
  output logic                   divresp_val,
  input  logic                   divresp_rdy,
  input  logic                   sub_out64,
  input  logic                   counter_is_zero,
  output logic                   is_op_signed,
  output logic                   a_mux_sel,
  output logic                   sub_mux_sel,
  output logic                   a_en,
  output logic                   b_en,
  output logic                   cntr_mux_sel,
  output logic                   sign_en
);

  import imuldiv_pkg::*;

  div_state_t state;
  logic       signed_reg;
  logic       req_go;
  logic       resp_go;

  // handshake transfers
  assign req_go  = divreq_val && divreq_rdy;
  assign resp_go = divresp_val && divresp_rdy;

  // state and the signed flag of the operation in flight
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= st_idle;
      signed_reg <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state      <= st_calc;
            signed_reg <= (divreq_fn == fn_div);
          end
        end
        // counter reaches zero on the last of the 32 iterations
        st_calc: begin
          if (counter_is_zero) begin
            state <= st_done;
          end
        end
        st_done: begin
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // in idle the signed flag comes straight from the request for the operand load
  assign is_op_signed = (state == st_idle) ? (divreq_fn == fn_div) : signed_reg;

  always_comb begin
    divreq_rdy   = 1'b0;
    divresp_val  = 1'b0;
    a_en         = 1'b0;
    b_en         = 1'b0;
    a_mux_sel    = 1'b0;
    sub_mux_sel  = 1'b0;
    cntr_mux_sel = 1'b0;
    sign_en      = 1'b0;
    case (state)
      st_idle: begin
        divreq_rdy = 1'b1;
        // load operands and capture signs on acceptance
        a_en       = req_go;
        b_en       = req_go;
        sign_en    = req_go;
      end
      st_calc: begin
        a_en         = 1'b1;
        a_mux_sel    = 1'b1;
        // negative difference means restore
        sub_mux_sel  = sub_out64;
        cntr_mux_sel = 1'b1;
      end
      st_done: begin
        divresp_val = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// ==== design/int_div_dpath.sv ====
//--------------------------------------------------------------------------
// divider datapath; operand magnitudes, restoring shift-subtract register
// pair, iteration counter and final sign correction of both halves
//--------------------------------------------------------------------------

module int_div_dpath (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [imuldiv_pkg::data_width-1:0]  divreq_a,
  input  logic [imuldiv_pkg::data_width-1:0]  divreq_b,
  input  logic                                a_en,
  input  logic                                b_en,
  input  logic                                a_mux_sel,
  input  logic                                sub_mux_sel,
  input  logic                                cntr_mux_sel,
  input  logic                                sign_en,
  input  logic                                is_op_signed,
  output logic                                sub_out64,
  output logic                                counter_is_zero,
  output imuldiv_pkg::muldiv_result_u         divresp_result
);

  import imuldiv_pkg::*;

  logic [2*data_width:0]   a_reg;
  logic [2*data_width:0]   b_reg;
  logic [cntr_width-1:0]   counter_reg;
  logic                    div_sign_reg;
  logic                    rem_sign_reg;

  logic [data_width-1:0]   a_mag;
  logic [data_width-1:0]   b_mag;
  logic [2*data_width:0]   a_shift;
  logic [2*data_width:0]   sub_diff;
  logic [2*data_width:0]   sub_mux_out;
  logic                    rem_sign_mux_sel;
  logic                    div_sign_mux_sel;
  logic [data_width-1:0]   quotient;
  logic [data_width-1:0]   remainder;

  //------------------------------------------------------------------------
  // operand load
  //------------------------------------------------------------------------

  // magnitudes only in signed mode
  assign a_mag = (is_op_signed && divreq_a[data_width-1]) ? -divreq_a : divreq_a;
  assign b_mag = (is_op_signed && divreq_b[data_width-1]) ? -divreq_b : divreq_b;

  //------------------------------------------------------------------------
  // one restoring iteration
  //------------------------------------------------------------------------

  assign a_shift  = {a_reg[2*data_width-1:0], 1'b0};
  assign sub_diff = a_shift - b_reg;
  // sign of the trial difference, back to control
  assign sub_out64 = sub_diff[2*data_width];

  // restore keeps the shifted value with a zero quotient bit
  assign sub_mux_out = sub_mux_sel ? a_shift : {sub_diff[2*data_width:1], 1'b1};

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_mux_sel ? sub_mux_out : {{(data_width+1){1'b0}}, a_mag};
    end
    // divisor sits aligned with the upper half
    if (b_en) begin
      b_reg <= {1'b0, b_mag, {data_width{1'b0}}};
    end
    if (sign_en) begin
      div_sign_reg <= divreq_a[data_width-1] ^ divreq_b[data_width-1];
      rem_sign_reg <= divreq_a[data_width-1];
    end
  end

  // counts down during calc, reloaded otherwise
  always_ff @(posedge clk) begin
    if (reset) begin
      counter_reg <= iter_count_max;
    end else begin
      counter_reg <= cntr_mux_sel ? counter_reg - 1'b1 : iter_count_max;
    end
  end

  assign counter_is_zero = (counter_reg == '0);

  //------------------------------------------------------------------------
  // sign correction
  //------------------------------------------------------------------------

  assign div_sign_mux_sel = div_sign_reg && is_op_signed;
  assign rem_sign_mux_sel = rem_sign_reg && is_op_signed;

  assign quotient  = a_reg[data_width-1:0];
  assign remainder = a_reg[2*data_width-1:data_width];

  always_comb begin
    divresp_result.divres.quotient  = div_sign_mux_sel ? -quotient : quotient;
    divresp_result.divres.remainder = rem_sign_mux_sel ? -remainder : remainder;
  end

endmodule

// ==== design/int_div_iterative.sv ====
//--------------------------------------------------------------------------
// iterative divider block; joins the divide control FSM and datapath
// behind one val/rdy request port and one response port
//--------------------------------------------------------------------------

module int_div_iterative (
  input  logic                                clk,
  input  logic                                reset,
  input  imuldiv_pkg::muldiv_fn_t             divreq_fn,
  input  logic [imuldiv_pkg::data_width-1:0]  divreq_a,
  input  logic [imuldiv_pkg::data_width-1:0]  divreq_b,
  input  logic                                divreq_val,
  output logic                                divreq_rdy,
  output imuldiv_pkg::muldiv_result_u         divresp_result,
  output logic                                divresp_val,
  input  logic                                divresp_rdy
);

  // control to datapath
  logic a_en;
  logic b_en;
  logic a_mux_sel;
  logic sub_mux_sel;
  logic cntr_mux_sel;
  logic sign_en;
  logic is_op_signed;
  // datapath to control
  logic sub_out64;
  logic counter_is_zero;

  int_div_ctrl u_int_div_ctrl (
    .clk             (clk),
    .reset           (reset),
    .divreq_fn       (divreq_fn),
    .divreq_val      (divreq_val),
    .divreq_rdy      (divreq_rdy),
    .divresp_val     (divresp_val),
    .divresp_rdy     (divresp_rdy),
    .sub_out64       (sub_out64),
    .counter_is_zero (counter_is_zero),
    .is_op_signed    (is_op_signed),
    .a_mux_sel       (a_mux_sel),
    .sub_mux_sel     (sub_mux_sel),
    .a_en            (a_en),
    .b_en            (b_en),
    .cntr_mux_sel    (cntr_mux_sel),
    .sign_en         (sign_en)
  );

  int_div_dpath u_int_div_dpath (
    .clk             (clk),
    .reset           (reset),
    .divreq_a        (divreq_a),
    .divreq_b        (divreq_b),
    .a_en            (a_en),
    .b_en            (b_en),
    .a_mux_sel       (a_mux_sel),
    .sub_mux_sel     (sub_mux_sel),
    .cntr_mux_sel    (cntr_mux_sel),
    .sign_en         (sign_en),
    .is_op_signed    (is_op_signed),
    .sub_out64       (sub_out64),
    .counter_is_zero (counter_is_zero),
    .divresp_result  (divresp_result)
  );

endmodule

// ==== design/int_mul_iterative.sv ====
//--------------------------------------------------------------------------
// iterative signed multiplier; shift-add on operand magnitudes over 32
// cycles, then sign correction of the 64-bit product
//--------------------------------------------------------------------------

module int_mul_iterative (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [imuldiv_pkg::data_width-1:0]  mulreq_a,
  input  logic [imuldiv_pkg::data_width-1:0]  mulreq_b,
  input  logic                                mulreq_val,
  output logic                                mulreq_rdy,
  output imuldiv_pkg::muldiv_result_u         mulresp_result,
  output logic                                mulresp_val,
  input  logic                                mulresp_rdy
);

  import imuldiv_pkg::*;

  div_state_t              state;
  logic [cntr_width-1:0]   counter_reg;
  logic [2*data_width-1:0] mcand_reg;
  logic [data_width-1:0]   mplier_reg;
  logic [2*data_width-1:0] prod_reg;
  logic                    neg_reg;
  logic                    req_go;
  logic                    resp_go;

  assign req_go  = mulreq_val && mulreq_rdy;
  assign resp_go = mulresp_val && mulresp_rdy;

  // FSM and iteration counter, same timing as the divider
  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= st_idle;
      counter_reg <= iter_count_max;
    end else begin
      case (state)
        st_idle: begin
          counter_reg <= iter_count_max;
          if (req_go) begin
            state <= st_calc;
          end
        end
        st_calc: begin
          counter_reg <= counter_reg - 1'b1;
          if (counter_reg == '0) begin
            state <= st_done;
          end
        end
        st_done: begin
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  //------------------------------------------------------------------------
  // shift-add datapath
  //------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (req_go) begin
      // unsigned magnitudes, product cleared
      mcand_reg  <= {{data_width{1'b0}},
                     mulreq_a[data_width-1] ? -mulreq_a : mulreq_a};
      mplier_reg <= mulreq_b[data_width-1] ? -mulreq_b : mulreq_b;
      prod_reg   <= '0;
      neg_reg    <= mulreq_a[data_width-1] ^ mulreq_b[data_width-1];
    end else if (state == st_calc) begin
      // add the shifted multiplicand for each set multiplier bit
      if (mplier_reg[0]) begin
        prod_reg <= prod_reg + mcand_reg;
      end
      mcand_reg  <= mcand_reg << 1;
      mplier_reg <= mplier_reg >> 1;
    end
  end

  assign mulreq_rdy  = (state == st_idle);
  assign mulresp_val = (state == st_done);

  // negate when the operand signs differ
  assign mulresp_result.product = neg_reg ? -prod_reg : prod_reg;

endmodule

// ==== design/int_muldiv_unit.sv ====
//--------------------------------------------------------------------------
// multiply/divide unit top level; steers each request to the multiplier
// or divider by function code and returns one response at a time
//--------------------------------------------------------------------------

module int_muldiv_unit (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                req_val,
  output logic                                req_rdy,
  input  imuldiv_pkg::muldiv_fn_t             req_fn,
  input  logic [imuldiv_pkg::data_width-1:0]  req_a,
  input  logic [imuldiv_pkg::data_width-1:0]  req_b,
  output logic                                resp_val,
  input  logic                                resp_rdy,
  output imuldiv_pkg::muldiv_result_u         resp_result
);

  import imuldiv_pkg::*;

  logic           sel_mul;
  logic           busy;
  logic           owner_mul;
  // per-unit handshakes
  logic           mul_req_val;
  logic           mul_req_rdy;
  logic           mul_resp_val;
  logic           mul_resp_rdy;
  muldiv_result_u mul_result;
  logic           div_req_val;
  logic           div_req_rdy;
  logic           div_resp_val;
  logic           div_resp_rdy;
  muldiv_result_u div_result;

  //------------------------------------------------------------------------
  // request steering
  //------------------------------------------------------------------------

  assign sel_mul = (req_fn == fn_mul);

  // no unit sees a request while an operation is outstanding
  assign mul_req_val = req_val && !busy && sel_mul;
  assign div_req_val = req_val && !busy && !sel_mul;
  assign req_rdy     = !busy && (sel_mul ? mul_req_rdy : div_req_rdy);

  // busy flag and owning unit, responses carry no tag
  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      owner_mul <= 1'b0;
    end else if (req_val && req_rdy) begin
      busy      <= 1'b1;
      owner_mul <= sel_mul;
    end else if (resp_val && resp_rdy) begin
      busy <= 1'b0;
    end
  end

  //------------------------------------------------------------------------
  // response return from the owner
  //------------------------------------------------------------------------

  assign resp_val     = owner_mul ? mul_resp_val : div_resp_val;
  assign resp_result  = owner_mul ? mul_result : div_result;
  assign mul_resp_rdy = resp_rdy && owner_mul;
  assign div_resp_rdy = resp_rdy && !owner_mul;

  int_mul_iterative u_int_mul_iterative (
    .clk            (clk),
    .reset          (reset),
    .mulreq_a       (req_a),
    .mulreq_b       (req_b),
    .mulreq_val     (mul_req_val),
    .mulreq_rdy     (mul_req_rdy),
    .mulresp_result (mul_result),
    .mulresp_val    (mul_resp_val),
    .mulresp_rdy    (mul_resp_rdy)
  );

  int_div_iterative u_int_div_iterative (
    .clk            (clk),
    .reset          (reset),
    .divreq_fn      (req_fn),
    .divreq_a       (req_a),
    .divreq_b       (req_b),
    .divreq_val     (div_req_val),
    .divreq_rdy     (div_req_rdy),
    .divresp_result (div_result),
    .divresp_val    (div_resp_val),
    .divresp_rdy    (div_resp_rdy)
  );

endmodule

// ==== bench/int_muldiv_chk.sv ====
//--------------------------------------------------------------------------
// handshake assertions on the multiply/divide unit top level, bound in
//--------------------------------------------------------------------------

module int_muldiv_chk (
  input logic                        clk,
  input logic                        reset,
  input logic                        req_rdy,
  input logic                        resp_val,
  input logic                        resp_rdy,
  input imuldiv_pkg::muldiv_result_u resp_result
);

  timeunit 1ns;
  timeprecision 100ps;

  // stalled response keeps its value
  a_result_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> $stable(resp_result))
    else $error("response result changed while stalled");

  // one operation in flight, no request while a response waits
  a_no_req_on_resp: assert property (@(posedge clk) disable iff (reset)
    resp_val |-> !req_rdy)
    else $error("request port ready while a response is pending");

  a_reset_quiet: assert property (@(posedge clk) reset |=> !resp_val)
    else $error("response valid right after reset");

endmodule

bind int_muldiv_unit int_muldiv_chk u_int_muldiv_chk (
  .clk         (clk),
  .reset       (reset),
  .req_rdy     (req_rdy),
  .resp_val    (resp_val),
  .resp_rdy    (resp_rdy),
  .resp_result (resp_result)
);

// ==== bench/int_muldiv_tb.sv ====
//--------------------------------------------------------------------------
// directed testbench of the multiply/divide unit; runs divide, multiply,
// latency, back-pressure and back-to-back tests, then prints the verdict
//--------------------------------------------------------------------------

module int_muldiv_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import imuldiv_pkg::*;

  // watchdog budget per operation plus room for stalls and reset
  localparam int op_count   = 51;
  localparam int op_cycles  = 40;
  localparam int margin     = 200;
  localparam int wait_limit = 100;

  logic                  clk;
  logic                  reset;
  logic                  req_val;
  logic                  req_rdy;
  muldiv_fn_t            req_fn;
  logic [data_width-1:0] req_a;
  logic [data_width-1:0] req_b;
  logic                  resp_val;
  logic                  resp_rdy;
  muldiv_result_u        resp_result;

  int                    errors;
  int                    checks;
  integer                seed = 32'h61953c59;
  // expected results and their function codes in request order
  muldiv_result_u        exp_q[$];
  muldiv_fn_t            fn_q[$];

  int_muldiv_unit u_int_muldiv_unit (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //------------------------------------------------------------------------
  // reference results from integer arithmetic
  //------------------------------------------------------------------------

  function automatic muldiv_result_u expect_result(muldiv_fn_t fn,
      logic [data_width-1:0] a, logic [data_width-1:0] b);
    muldiv_result_u r;
    longint         ea;
    longint         eb;
    int             sa;
    int             sb;
    ea = $signed(a);
    eb = $signed(b);
    sa = a;
    sb = b;
    r  = '0;
    case (fn)
      fn_mul: r.product = ea * eb;
      // int division truncates toward zero and the remainder follows the dividend
      fn_div: begin
        r.divres.quotient  = sa / sb;
        r.divres.remainder = sa % sb;
      end
      default: begin
        if (b == '0) begin
          r.divres.quotient  = '1;
          r.divres.remainder = a;
        end else begin
          r.divres.quotient  = a / b;
          r.divres.remainder = a % b;
        end
      end
    endcase
    return r;
  endfunction

  //------------------------------------------------------------------------
  // compare tasks
  //------------------------------------------------------------------------

  task automatic check_product(string name, muldiv_result_u exp, muldiv_result_u act);
    checks++;
    if (act.product !== exp.product) begin
      errors++;
      $display("FAILED %s: expected %h, got %h", name, exp.product, act.product);
    end
  endtask

  task automatic check_divres(string name, muldiv_result_u exp, muldiv_result_u act);
    checks++;
    if (act.divres !== exp.divres) begin
      errors++;
      $display("FAILED %s: expected q=%h r=%h, got q=%h r=%h", name,
               exp.divres.quotient, exp.divres.remainder,
               act.divres.quotient, act.divres.remainder);
    end
  endtask

  task automatic check_count(string name, int exp, int act);
    checks++;
    if (act != exp) begin
      errors++;
      $display("FAILED %s: expected %0d, got %0d", name, exp, act);
    end
  endtask

  task automatic check_result(string name, muldiv_fn_t fn, muldiv_result_u exp,
      muldiv_result_u act);
    if (fn == fn_mul) begin
      check_product(name, exp, act);
    end else begin
      check_divres(name, exp, act);
    end
  endtask

  //------------------------------------------------------------------------
  // handshake helpers entered and left 1 ns after a rising edge
  //------------------------------------------------------------------------

  task automatic send_req(muldiv_fn_t fn, logic [data_width-1:0] a,
      logic [data_width-1:0] b);
    int n;
    n       = 0;
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    req_val = 1'b1;
    exp_q.push_back(expect_result(fn, a, b));
    fn_q.push_back(fn);
    // req_rdy follows req_fn and is sampled later in the cycle
    #1;
    while (!req_rdy && n < wait_limit) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (!req_rdy) begin
      errors++;
      $display("request was never accepted by the unit");
    end
    // accepting edge
    @(posedge clk);
    #1;
    req_val = 1'b0;
  endtask

  // cycles from the accepting edge until resp_val is seen
  task automatic wait_resp(output int lat);
    lat = 0;
    while (!resp_val && lat < wait_limit) begin
      @(posedge clk);
      #1;
      lat++;
    end
    if (!resp_val) begin
      errors++;
      $display("no response arrived after a request");
    end
  endtask

  task automatic take_resp(string name);
    muldiv_result_u exp;
    muldiv_fn_t     fn;
    exp = exp_q.pop_front();
    fn  = fn_q.pop_front();
    check_result(name, fn, exp, resp_result);
    resp_rdy = 1'b1;
    @(posedge clk);
    #1;
  endtask

  task automatic run_op(string name, muldiv_fn_t fn, logic [data_width-1:0] a,
      logic [data_width-1:0] b, output int lat);
    send_req(fn, a, b);
    wait_resp(lat);
    take_resp(name);
  endtask

  //------------------------------------------------------------------------
  // directed tests
  //------------------------------------------------------------------------

  task automatic test_divu();
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
    int                    lat;
    run_op("divu fixed", fn_divu, 32'd100, 32'd7, lat);
    run_op("divu small dividend", fn_divu, 32'd5, 32'd9, lat);
    run_op("divu large", fn_divu, 32'hffff_ffff, 32'h0001_0000, lat);
    run_op("divu by one", fn_divu, 32'hdead_beef, 32'd1, lat);
    run_op("divu by zero", fn_divu, 32'h1234_5678, 32'd0, lat);
    repeat (8) begin
      a = $random(seed);
      b = $random(seed);
      // spread the divisor over all magnitudes
      b = b >> ({$random(seed)} % 32);
      run_op("divu random", fn_divu, a, b, lat);
    end
  endtask

  task automatic test_div();
    int lat;
    run_op("div pos pos", fn_div, 32'd100, 32'd7, lat);
    run_op("div neg pos", fn_div, -32'd100, 32'd7, lat);
    run_op("div pos neg", fn_div, 32'd100, -32'd7, lat);
    run_op("div neg neg", fn_div, -32'd100, -32'd7, lat);
    run_op("div small neg", fn_div, 32'd7, -32'd100, lat);
    run_op("div exact", fn_div, -32'd12345, 32'd5, lat);
  endtask

  task automatic test_mul();
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
    int                    lat;
    run_op("mul pos pos", fn_mul, 32'd1234, 32'd5678, lat);
    run_op("mul neg pos", fn_mul, -32'd1234, 32'd5678, lat);
    run_op("mul pos neg", fn_mul, 32'd1234, -32'd5678, lat);
    run_op("mul neg neg", fn_mul, -32'd1234, -32'd5678, lat);
    run_op("mul zero a", fn_mul, 32'd0, 32'h8765_4321, lat);
    run_op("mul zero b", fn_mul, 32'hffff_fff0, 32'd0, lat);
    run_op("mul min min", fn_mul, 32'h8000_0000, 32'h8000_0000, lat);
    repeat (8) begin
      a = $random(seed);
      b = $random(seed);
      run_op("mul random", fn_mul, a, b, lat);
    end
  endtask

  task automatic test_latency();
    int lat;
    run_op("latency divu", fn_divu, 32'd1000, 32'd3, lat);
    check_count("latency divu", 32, lat);
    run_op("latency mul", fn_mul, 32'd1000, -32'd3, lat);
    check_count("latency mul", 32, lat);
  endtask

  task automatic test_backpressure();
    muldiv_fn_t            fn;
    muldiv_fn_t            next_fn;
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
    logic [data_width-1:0] na;
    logic [data_width-1:0] nb;
    int                    stall;
    int                    lat;
    for (int i = 0; i < 3; i++) begin
      fn      = (i % 2 == 0) ? fn_divu : fn_mul;
      next_fn = (fn == fn_mul) ? fn_div : fn_mul;
      a       = $random(seed);
      b       = $random(seed);
      na      = $random(seed);
      // signed divisor kept small and nonzero
      nb      = ({$random(seed)} % 1000) + 1;
      stall   = {$random(seed)} % 11;
      resp_rdy = 1'b0;
      send_req(fn, a, b);
      wait_resp(lat);
      // next request waits at the port while the response is stalled
      req_fn  = next_fn;
      req_a   = na;
      req_b   = nb;
      req_val = 1'b1;
      repeat (stall) begin
        @(posedge clk);
        #1;
        check_result("backpressure hold", fn, exp_q[0], resp_result);
        if (req_rdy || !resp_val) begin
          errors++;
          $display("request port opened or response dropped during a stall");
        end
      end
      take_resp("backpressure first");
      run_op("backpressure queued", next_fn, na, nb, lat);
    end
  endtask

  task automatic test_back_to_back();
    muldiv_fn_t            fn;
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
    int                    lat;
    resp_rdy = 1'b1;
    for (int i = 0; i < 9; i++) begin
      a = $random(seed);
      b = $random(seed);
      case (i % 3)
        0: fn = fn_mul;
        1: begin
          fn = fn_div;
          // nonzero divisor of either sign keeps clear of the overflow case
          b = ({$random(seed)} % 5000) + 1;
          if (a[0]) begin
            b = -b;
          end
          if (a == 32'h8000_0000) begin
            a = '0;
          end
        end
        default: fn = fn_divu;
      endcase
      run_op("back to back", fn, a, b, lat);
    end
  endtask

  //------------------------------------------------------------------------
  // main sequence and watchdog
  //------------------------------------------------------------------------

  initial begin
    errors   = 0;
    checks   = 0;
    reset    = 1'b1;
    req_val  = 1'b0;
    req_fn   = fn_mul;
    req_a    = '0;
    req_b    = '0;
    resp_rdy = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    checks++;
    if (!req_rdy || resp_val) begin
      errors++;
      $display("unit is not idle after reset");
    end
    resp_rdy = 1'b1;
    test_divu();
    test_div();
    test_mul();
    test_latency();
    test_backpressure();
    test_back_to_back();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    repeat (op_count * op_cycles + margin) @(posedge clk);
    $display("watchdog expired before the tests finished");
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== list.f ====
design/imuldiv_pkg.sv
design/int_div_ctrl.sv
design/int_div_dpath.sv
design/int_div_iterative.sv
design/int_mul_iterative.sv
design/int_muldiv_unit.sv
bench/int_muldiv_chk.sv
bench/int_muldiv_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the multiply/divide unit testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=int_muldiv_sim
log_file=sim.log

verilator --binary --timing --assert --top-module int_muldiv_tb \
  -f list.f --Mdir "$build_dir" -o "$sim_bin"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "TEST OK" "$log_file"; then
  exit 0
fi
exit 1
